// ==== common/nabp_geom_pkg.sv ====
package nabp_geom_pkg;

    // projection line length in pixels
    localparam int IMAGE_SIZE = 16;

    // one processing element per line buffer tap
    localparam int NUM_PE = 4;
    // tap positions, ascending
    localparam int PE_TAPS [NUM_PE] = '{0, 4, 8, 12};

    // fill runs down from the last tap, shift runs down from the last pixel
    localparam int FILL_CNT_INIT = PE_TAPS[NUM_PE-1];
    localparam int SHIFT_CNT_INIT = IMAGE_SIZE - 1;
    localparam int CNT_W = $clog2(SHIFT_CNT_INIT + 1);
    // the shared down counter only works if fill never outruns shift
    localparam bit CNT_INIT_OK = (FILL_CNT_INIT <= SHIFT_CNT_INIT);

    // filtered pixels and line RAM addressing
    localparam int PIXEL_W = 12;
    localparam int ADDR_W = $clog2(IMAGE_SIZE);

    // unsigned fixed point step accumulator, 4.8
    localparam int ACCU_INT_W = 4;
    localparam int ACCU_FRAC_W = 8;
    localparam int ACCU_W = ACCU_INT_W + ACCU_FRAC_W;

    // PE sums, wide enough for a full line of pixels
    localparam int SUM_W = 18;

    typedef logic [ACCU_W-1:0] accu_t;
    typedef logic signed [PIXEL_W-1:0] pixel_t;
    typedef logic signed [SUM_W-1:0] sum_t;

endpackage

// ==== common/nabp_ctrl_pkg.sv ====
package nabp_ctrl_pkg;

    // shifter phases
    typedef enum logic [1:0] {
        READY_S     = 2'd0,
        FILL_S      = 2'd1,
        FILL_DONE_S = 2'd2,
        SHIFT_S     = 2'd3
    } shifter_state_t;

    // run controller phases
    // encoding 3 is unused and falls back to idle
    typedef enum logic [1:0] {
        IDLE_S     = 2'd0,
        FILLING_S  = 2'd1,
        SHIFTING_S = 2'd2
    } run_state_t;

endpackage

// ==== hdl/nabp_state_control.sv ====
module nabp_state_control
    import nabp_geom_pkg::*;
    import nabp_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  start,
    input  accu_t accu_base,
    input  logic  sc_fill_done,
    input  logic  sc_shift_done,
    output logic  sc_fill_kick,
    output logic  sc_shift_kick,
    output accu_t sc_accu_base,
    output logic  busy,
    output logic  done
);

    run_state_t state;
    accu_t      base_q;

    // run sequencing, kicks and done are one-cycle pulses
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state         <= IDLE_S;
            sc_fill_kick  <= 1'b0;
            sc_shift_kick <= 1'b0;
            done          <= 1'b0;
        end
        else
        begin
            sc_fill_kick  <= 1'b0;
            sc_shift_kick <= 1'b0;
            done          <= 1'b0;
            case (state)
                IDLE_S:
                    // start only counts while idle
                    if (start)
                    begin
                        state        <= FILLING_S;
                        sc_fill_kick <= 1'b1;
                    end
                FILLING_S:
                    if (sc_fill_done)
                    begin
                        state         <= SHIFTING_S;
                        sc_shift_kick <= 1'b1;
                    end
                SHIFTING_S:
                    // done and the fall of busy land together
                    if (sc_shift_done)
                    begin
                        state <= IDLE_S;
                        done  <= 1'b1;
                    end
                default:
                    state <= IDLE_S;
            endcase
        end
    end

    // base is held for the whole run
    always_ff @(posedge clk)
    begin
        if (state == IDLE_S && start)
            base_q <= accu_base;
    end

    assign sc_accu_base = base_q;
    assign busy = (state != IDLE_S);

    // a done from the shifter only answers the kick still waiting on it
    a_fill_done_pending: assert property (@(posedge clk) disable iff (!reset_n)
        sc_fill_done |-> state == FILLING_S);
    a_shift_done_pending: assert property (@(posedge clk) disable iff (!reset_n)
        sc_shift_done |-> state == SHIFTING_S);

endmodule

// ==== shifter/nabp_shifter.sv ====
module nabp_shifter
    import nabp_geom_pkg::*;
    import nabp_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    // kicks and step size from the run controller
    input  logic  sc_fill_kick,
    input  logic  sc_shift_kick,
    input  accu_t sc_accu_base,
    // phase ends back to the run controller
    output logic  sc_fill_done,
    output logic  sc_shift_done,
    // filter mapper control
    output logic  mp_kick,
    output logic  mp_shift_en,
    // line buffer control
    output logic  lb_clear,
    output logic  lb_shift_en,
    // PE array control
    output logic  sw_pe_kick
);

    shifter_state_t state;
    shifter_state_t next_state;
    logic [CNT_W-1:0] cnt;
    accu_t accu;
    accu_t accu_next;
    logic fill_done_l;
    logic shift_done_l;
    logic [1:0] fill_done_d;
    logic [1:0] shift_done_d;

    // fill and shift share one down counter
    if (!CNT_INIT_OK)
    begin : g_cnt_check
        $fatal(1, "fill count %0d exceeds shift count %0d", FILL_CNT_INIT, SHIFT_CNT_INIT);
    end

    // wraps freely, only integer boundary crossings matter
    assign accu_next = accu + sc_accu_base;

    // every fill cycle shifts, shift cycles only on a crossing
    assign mp_shift_en = (state == FILL_S) ||
                         (state == SHIFT_S &&
                          accu_next[ACCU_W-1 -: ACCU_INT_W] != accu[ACCU_W-1 -: ACCU_INT_W]);

    assign fill_done_l  = (state == FILL_S) && (cnt == '0);
    assign shift_done_l = (state == SHIFT_S) && (cnt == '0);

    // a new run starts from an empty buffer and address 0
    assign lb_clear = sc_fill_kick;
    assign mp_kick  = sc_fill_kick;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cnt  <= CNT_W'(FILL_CNT_INIT);
            accu <= '0;
        end
        else
        begin
            case (state)
                FILL_S:
                    if (cnt != '0)
                        cnt <= cnt - 1'b1;
                FILL_DONE_S:
                    cnt <= CNT_W'(SHIFT_CNT_INIT);
                SHIFT_S:
                    if (cnt != '0)
                    begin
                        cnt  <= cnt - 1'b1;
                        accu <= accu_next;
                    end
                default:
                begin
                    cnt <= CNT_W'(FILL_CNT_INIT);
                    // half a step up front so shifts fall on pixel edges
                    // rather than on pixel centres
                    accu <= sc_accu_base >> 1;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= READY_S;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            READY_S:
                if (sc_fill_kick)
                    next_state = FILL_S;
            FILL_S:
                if (fill_done_l)
                    next_state = FILL_DONE_S;
            FILL_DONE_S:
                if (sc_shift_kick)
                    next_state = SHIFT_S;
            SHIFT_S:
                if (shift_done_l)
                    next_state = READY_S;
            default:
                next_state = READY_S;
        endcase
    end

    // one cycle covers the RAM read, done strobes trail by two
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            lb_shift_en  <= 1'b0;
            sw_pe_kick   <= 1'b0;
            fill_done_d  <= '0;
            shift_done_d <= '0;
        end
        else
        begin
            lb_shift_en  <= mp_shift_en;
            sw_pe_kick   <= sc_shift_kick;
            fill_done_d  <= {fill_done_d[0], fill_done_l};
            shift_done_d <= {shift_done_d[0], shift_done_l};
        end
    end

    assign sc_fill_done  = fill_done_d[1];
    assign sc_shift_done = shift_done_d[1];

    // kicks from the controller must match the shifter phase
    a_fill_kick_ready: assert property (@(posedge clk) disable iff (!reset_n)
        sc_fill_kick |-> state == READY_S);
    a_shift_kick_fill_done: assert property (@(posedge clk) disable iff (!reset_n)
        sc_shift_kick |-> state == FILL_DONE_S);

endmodule

// ==== hdl/nabp_filter_mapper.sv ====
module nabp_filter_mapper
    import nabp_geom_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    // host load port
    input  logic              fp_we,
    input  logic [ADDR_W-1:0] fp_addr,
    input  pixel_t            fp_data,
    // read control from the shifter
    input  logic              mp_kick,
    input  logic              mp_shift_en,
    output pixel_t            rd_data
);

    pixel_t mem [IMAGE_SIZE];
    logic [ADDR_W-1:0] rd_addr;
    // set once the last pixel has been read out
    logic rd_over;

    // host write port
    always_ff @(posedge clk)
    begin
        if (fp_we)
            mem[fp_addr] <= fp_data;
    end

    // sequential read address
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_addr <= '0;
            rd_over <= 1'b0;
        end
        else if (mp_kick)
        begin
            rd_addr <= '0;
            rd_over <= 1'b0;
        end
        else if (mp_shift_en)
        begin
            rd_addr <= rd_addr + 1'b1;
            if (rd_addr == ADDR_W'(IMAGE_SIZE - 1))
                rd_over <= 1'b1;
        end
    end

    // read data follows each shift enable by one cycle
    // zeros are fed in past the end of the line
    always_ff @(posedge clk)
    begin
        if (mp_shift_en)
        begin
            if (rd_over)
                rd_data <= '0;
            else
                rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== line_buffer/nabp_line_buffer.sv ====
module nabp_line_buffer
    import nabp_geom_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   lb_clear,
    input  logic   lb_shift_en,
    input  pixel_t rd_data,
    output pixel_t tap_pixels [NUM_PE]
);

    pixel_t line_q [IMAGE_SIZE];

    // new pixels enter at 0 and move up one slot per shift
    always_ff @(posedge clk)
    begin
        if (!reset_n || lb_clear)
        begin
            for (int i = 0; i < IMAGE_SIZE; i++)
                line_q[i] <= '0;
        end
        else if (lb_shift_en)
        begin
            line_q[0] <= rd_data;
            for (int i = 1; i < IMAGE_SIZE; i++)
                line_q[i] <= line_q[i-1];
        end
    end

    // expose the slots under the PE taps
    for (genvar g = 0; g < NUM_PE; g++)
    begin : g_tap
        assign tap_pixels[g] = line_q[PE_TAPS[g]];
    end

    // clear comes with the fill kick, before any shift reaches us
    a_clear_no_shift: assert property (@(posedge clk) disable iff (!reset_n)
        !(lb_clear && lb_shift_en));

endmodule

// ==== hdl/nabp_pe_array.sv ====
module nabp_pe_array
    import nabp_geom_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   sw_pe_kick,
    input  logic   lb_shift_en,
    input  pixel_t tap_pixels [NUM_PE],
    output sum_t   pe_sums [NUM_PE]
);

    // high over the shift-phase window after a kick
    logic active;
    // shift phase spans SHIFT_CNT_INIT+1 cycles after the kick
    logic [CNT_W-1:0] win_cnt;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            active  <= 1'b0;
            win_cnt <= '0;
        end
        else if (sw_pe_kick)
        begin
            active  <= 1'b1;
            win_cnt <= CNT_W'(SHIFT_CNT_INIT);
        end
        else if (active)
        begin
            if (win_cnt == '0)
                active <= 1'b0;
            else
                win_cnt <= win_cnt - 1'b1;
        end
    end

    // each PE adds the pixel under its tap on every shift of the window
    // the tap value is the one held before that shift lands
    always_ff @(posedge clk)
    begin
        if (!reset_n || sw_pe_kick)
        begin
            for (int i = 0; i < NUM_PE; i++)
                pe_sums[i] <= '0;
        end
        else if (active && lb_shift_en)
        begin
            for (int i = 0; i < NUM_PE; i++)
                pe_sums[i] <= pe_sums[i] + tap_pixels[i];
        end
    end

endmodule

// ==== hdl/nabp_top.sv ====
module nabp_top
(
    input  logic                                 clk,
    input  logic                                 reset_n,
    // line RAM load, only while not busy
    input  logic                                 fp_we,
    input  logic [nabp_geom_pkg::ADDR_W-1:0]     fp_addr,
    input  nabp_geom_pkg::pixel_t                fp_data,
    // run control
    input  logic                                 start,
    input  nabp_geom_pkg::accu_t                 accu_base,
    output logic                                 busy,
    output logic                                 done,
    // per-tap sums, stable from done to the next start
    output nabp_geom_pkg::sum_t                  pe_sums [nabp_geom_pkg::NUM_PE]
);

    logic sc_fill_kick;
    logic sc_shift_kick;
    logic sc_fill_done;
    logic sc_shift_done;
    nabp_geom_pkg::accu_t sc_accu_base;
    logic mp_kick;
    logic mp_shift_en;
    logic lb_clear;
    logic lb_shift_en;
    logic sw_pe_kick;
    nabp_geom_pkg::pixel_t rd_data;
    nabp_geom_pkg::pixel_t tap_pixels [nabp_geom_pkg::NUM_PE];

    // start/done sequencing
    nabp_state_control u_state_control (
        .clk           (clk),
        .reset_n       (reset_n),
        .start         (start),
        .accu_base     (accu_base),
        .sc_fill_done  (sc_fill_done),
        .sc_shift_done (sc_shift_done),
        .sc_fill_kick  (sc_fill_kick),
        .sc_shift_kick (sc_shift_kick),
        .sc_accu_base  (sc_accu_base),
        .busy          (busy),
        .done          (done)
    );

    // fill and shift strobes for the datapath
    nabp_shifter u_shifter (
        .clk           (clk),
        .reset_n       (reset_n),
        .sc_fill_kick  (sc_fill_kick),
        .sc_shift_kick (sc_shift_kick),
        .sc_accu_base  (sc_accu_base),
        .sc_fill_done  (sc_fill_done),
        .sc_shift_done (sc_shift_done),
        .mp_kick       (mp_kick),
        .mp_shift_en   (mp_shift_en),
        .lb_clear      (lb_clear),
        .lb_shift_en   (lb_shift_en),
        .sw_pe_kick    (sw_pe_kick)
    );

    nabp_filter_mapper u_filter_mapper (
        .clk         (clk),
        .reset_n     (reset_n),
        .fp_we       (fp_we),
        .fp_addr     (fp_addr),
        .fp_data     (fp_data),
        .mp_kick     (mp_kick),
        .mp_shift_en (mp_shift_en),
        .rd_data     (rd_data)
    );

    nabp_line_buffer u_line_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .lb_clear    (lb_clear),
        .lb_shift_en (lb_shift_en),
        .rd_data     (rd_data),
        .tap_pixels  (tap_pixels)
    );

    nabp_pe_array u_pe_array (
        .clk         (clk),
        .reset_n     (reset_n),
        .sw_pe_kick  (sw_pe_kick),
        .lb_shift_en (lb_shift_en),
        .tap_pixels  (tap_pixels),
        .pe_sums     (pe_sums)
    );

endmodule

// ==== dv/nabp_clock_gen.sv ====
module nabp_clock_gen
(
    output logic clk,
    output logic reset_n
);

    // 20 unit period
    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    // reset held low for ten rising edges, released mid-cycle
    initial
    begin
        reset_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

// ==== dv/nabp_tb.sv ====
module nabp_tb
    import nabp_geom_pkg::*;
();

    // upper bounds for every wait loop
    localparam int RUN_TIMEOUT = 200;
    localparam int RESET_TIMEOUT = 100;

    logic clk;
    logic reset_n;
    logic fp_we;
    logic [ADDR_W-1:0] fp_addr;
    pixel_t fp_data;
    logic start;
    accu_t accu_base;
    logic busy;
    logic done;
    sum_t pe_sums [NUM_PE];

    // line to load and the sums expected from it
    pixel_t line_mem [IMAGE_SIZE];
    sum_t exp_sums [NUM_PE];
    // model copy of the line buffer and its next source pixel
    pixel_t model_q [IMAGE_SIZE];
    int model_src;

    int error_count;
    int test_count;
    int failed_tests;
    int test_errors_at_start;

    nabp_clock_gen u_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    nabp_top uut (
        .clk       (clk),
        .reset_n   (reset_n),
        .fp_we     (fp_we),
        .fp_addr   (fp_addr),
        .fp_data   (fp_data),
        .start     (start),
        .accu_base (accu_base),
        .busy      (busy),
        .done      (done),
        .pe_sums   (pe_sums)
    );

    task automatic check_sum(input string name, input sum_t expected, input sum_t actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %0b, actual %0b", name, expected, actual);
            error_count++;
        end
    endtask

    // one pixel enters at slot 0, zeros once the line runs out
    task automatic shift_model();
        for (int i = IMAGE_SIZE - 1; i > 0; i--)
            model_q[i] = model_q[i-1];
        if (model_src < IMAGE_SIZE)
            model_q[0] = line_mem[model_src];
        else
            model_q[0] = '0;
        model_src++;
    endtask

    // replays fill and boundary-crossing shifts on line_mem
    task automatic compute_expected(input accu_t base);
        int accu;
        int accu_next;
        int sums [NUM_PE];
        for (int i = 0; i < IMAGE_SIZE; i++)
            model_q[i] = '0;
        for (int p = 0; p < NUM_PE; p++)
            sums[p] = 0;
        model_src = 0;
        // fill runs the buffer up to the last tap
        for (int n = 0; n <= FILL_CNT_INIT; n++)
            shift_model();
        // half step up front, 4.8 format wraps at 16
        accu = int'(base) >> 1;
        for (int n = 0; n <= SHIFT_CNT_INIT; n++)
        begin
            accu_next = (accu + int'(base)) % (1 << (ACCU_INT_W + ACCU_FRAC_W));
            if ((accu_next >> ACCU_FRAC_W) != (accu >> ACCU_FRAC_W))
            begin
                // taps see the buffer before this shift lands
                for (int p = 0; p < NUM_PE; p++)
                    sums[p] = sums[p] + model_q[PE_TAPS[p]];
                shift_model();
            end
            accu = accu_next;
        end
        for (int p = 0; p < NUM_PE; p++)
            exp_sums[p] = sum_t'(sums[p]);
    endtask

    // host writes the whole line while idle
    task automatic load_line(input string name);
        check_flag({name, " idle before load"}, 1'b0, busy);
        for (int i = 0; i < IMAGE_SIZE; i++)
        begin
            @(negedge clk);
            fp_we = 1'b1;
            fp_addr = ADDR_W'(i);
            fp_data = line_mem[i];
        end
        @(negedge clk);
        fp_we = 1'b0;
    endtask

    // pulse start, optionally poke start again mid-run, wait for done
    task automatic run_line(input string name, input accu_t base, input bit poke_start);
        int cycles;
        @(negedge clk);
        start = 1'b1;
        accu_base = base;
        @(negedge clk);
        start = 1'b0;
        accu_base = '0;
        check_flag({name, " busy after start"}, 1'b1, busy);
        cycles = 0;
        while (done !== 1'b1 && cycles < RUN_TIMEOUT)
        begin
            // stray start with another base, must be ignored
            if (poke_start && cycles == 8)
            begin
                start = 1'b1;
                accu_base = base ^ 12'h5a5;
            end
            else
                start = 1'b0;
            @(negedge clk);
            cycles++;
        end
        start = 1'b0;
        accu_base = '0;
        if (done !== 1'b1)
        begin
            $display("%s: done did not arrive within %0d cycles", name, RUN_TIMEOUT);
            error_count++;
        end
        else
            check_flag({name, " busy low at done"}, 1'b0, busy);
    endtask

    task automatic check_results(input string name);
        for (int p = 0; p < NUM_PE; p++)
            check_sum($sformatf("%s pe%0d", name, p), exp_sums[p], pe_sums[p]);
    endtask

    task automatic start_test();
        test_errors_at_start = error_count;
        test_count++;
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_errors_at_start)
            $display("test %s: pass", name);
        else
        begin
            $display("test %s: %0d errors", name, error_count - test_errors_at_start);
            failed_tests++;
        end
    endtask

    task automatic test_reset();
        int cycles;
        start_test();
        cycles = 0;
        while (reset_n !== 1'b1 && cycles < RESET_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (reset_n !== 1'b1)
        begin
            $display("reset: reset was never released");
            error_count++;
        end
        @(negedge clk);
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset done", 1'b0, done);
        for (int p = 0; p < NUM_PE; p++)
            check_sum($sformatf("reset pe%0d", p), '0, pe_sums[p]);
        finish_test("reset");
    endtask

    // no crossing ever, sums stay at their cleared value
    task automatic test_zero_base();
        start_test();
        for (int i = 0; i < IMAGE_SIZE; i++)
            line_mem[i] = pixel_t'(i + 1);
        load_line("zero_base");
        run_line("zero_base", 12'h000, 1'b0);
        for (int p = 0; p < NUM_PE; p++)
            check_sum($sformatf("zero_base pe%0d", p), '0, pe_sums[p]);
        finish_test("zero_base");
    endtask

    // one pixel step per cycle, ramp line
    task automatic test_unit_base();
        start_test();
        for (int i = 0; i < IMAGE_SIZE; i++)
            line_mem[i] = pixel_t'(10 * (i + 1));
        load_line("unit_base");
        compute_expected(12'h100);
        run_line("unit_base", 12'h100, 1'b0);
        check_results("unit_base");
        finish_test("unit_base");
    endtask

    // 0.375 step on random pixels
    task automatic test_frac_base();
        start_test();
        for (int i = 0; i < IMAGE_SIZE; i++)
            line_mem[i] = pixel_t'($urandom);
        load_line("frac_base");
        compute_expected(12'h060);
        run_line("frac_base", 12'h060, 1'b0);
        check_results("frac_base");
        finish_test("frac_base");
    endtask

    task automatic test_back_to_back();
        bit stray_busy;
        start_test();
        // first run, 0.625 step
        for (int i = 0; i < IMAGE_SIZE; i++)
            line_mem[i] = pixel_t'($urandom);
        load_line("b2b_first");
        compute_expected(12'h0a0);
        run_line("b2b_first", 12'h0a0, 1'b0);
        check_results("b2b_first");
        // second run, 1.75 step, with a start poked while busy
        for (int i = 0; i < IMAGE_SIZE; i++)
            line_mem[i] = pixel_t'(100 - 37 * i);
        load_line("b2b_second");
        compute_expected(12'h1c0);
        run_line("b2b_second", 12'h1c0, 1'b1);
        check_results("b2b_second");
        // the poked start must not launch another run
        stray_busy = 1'b0;
        for (int n = 0; n < 40; n++)
        begin
            @(negedge clk);
            stray_busy = stray_busy | busy;
        end
        check_flag("b2b busy after done", 1'b0, stray_busy);
        check_results("b2b_second held");
        finish_test("back_to_back");
    endtask

    initial
    begin
        fp_we = 1'b0;
        fp_addr = '0;
        fp_data = '0;
        start = 1'b0;
        accu_base = '0;
        error_count = 0;
        test_count = 0;
        failed_tests = 0;
        test_errors_at_start = 0;
        model_src = 0;
        void'($urandom(90771));

        test_reset();
        test_zero_base();
        test_unit_base();
        test_frac_base();
        test_back_to_back();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
common/nabp_geom_pkg.sv
common/nabp_ctrl_pkg.sv
hdl/nabp_state_control.sv
shifter/nabp_shifter.sv
hdl/nabp_filter_mapper.sv
line_buffer/nabp_line_buffer.sv
hdl/nabp_pe_array.sv
hdl/nabp_top.sv
dv/nabp_clock_gen.sv
dv/nabp_tb.sv

// ==== Bender.yml ====
package:
  name: nabp

sources:
  - files:
      - common/nabp_geom_pkg.sv
      - common/nabp_ctrl_pkg.sv
      - hdl/nabp_state_control.sv
      - shifter/nabp_shifter.sv
      - hdl/nabp_filter_mapper.sv
      - line_buffer/nabp_line_buffer.sv
      - hdl/nabp_pe_array.sv
      - hdl/nabp_top.sv
  - target: simulation
    files:
      - dv/nabp_clock_gen.sv
      - dv/nabp_tb.sv
